//--- build.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/mem_access.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
verification/tb_clock.sv
verification/cpu_tb_memory.sv
verification/cpu_tb.sv

//--- rtl/alu.sv
// Combinational ALU for the eight arithmetic and compare opcodes
`timescale 1ns/10ps

module alu (
	input  cpu_pkg::opcode_e op,
	input  cpu_pkg::word_t a,   // From register
	input  cpu_pkg::word_t b,   // If register
	output cpu_pkg::word_t result
);

	logic [31:0] product;

	assign product = 32'(a) * 32'(b);

	always_comb begin
		case (op)
			cpu_pkg::op_and: result = a & b;
			cpu_pkg::op_or:  result = a | b;
			cpu_pkg::op_xor: result = a ^ b;
			cpu_pkg::op_add: result = a + b;
			cpu_pkg::op_mul: result = product[15:0]; // Low half only
			cpu_pkg::op_gt:  result = (a > b) ? 16'hffff : 16'h0000;
			cpu_pkg::op_eq:  result = (a == b) ? 16'hffff : 16'h0000;
			cpu_pkg::op_shft: begin
				// Upper byte of b picks the direction
				if (b[7:4] != 4'h0) begin
					result = '0;
				end else if (b[15:8] != 8'h00) begin
					result = a << b[3:0];
				end else begin
					result = a >> b[3:0];
				end
			end
			default: result = a; // Pass-through for the moves
		endcase
	end

endmodule

//--- rtl/cpu_control.sv
// Instruction sequencer: fetch, execute per opcode, commit the register write, step the PC
`timescale 1ns/10ps

module cpu_control (
	input  logic clk,
	input  logic mem_read_ready_stor_reset,
	output cpu_pkg::word_t ins_addr,
	input  cpu_pkg::word_t ins_data,
	input  cpu_pkg::word_t pc,
	output cpu_pkg::reg_addr_t rd_from,
	output cpu_pkg::reg_addr_t rd_if,
	input  cpu_pkg::word_t rdata_if,
	output cpu_pkg::opcode_e alu_op,
	input  cpu_pkg::word_t alu_result,
	output logic mem_start,
	output logic mem_is_write,
	input  logic mem_done,
	input  cpu_pkg::word_t mem_rdata,
	output cpu_pkg::reg_write_t reg_wr,
	output logic [1:0] pc_step,
	output logic halted
);

	cpu_pkg::cpu_state_e state;
	cpu_pkg::instruction_t ins_buf; // Latched in ins_load
	cpu_pkg::instruction_t ins_word;
	logic set_phase;  // Second execute cycle of SET
	logic set_fetch;
	logic ins_is_mem;
	logic move_en;

	assign ins_word = cpu_pkg::instruction_t'(ins_data);
	assign ins_is_mem = (ins_word.op == cpu_pkg::op_memr) || (ins_word.op == cpu_pkg::op_memw);

	// SET reads its immediate from the word after the opcode
	assign set_fetch = (state == cpu_pkg::execute) && (ins_buf.op == cpu_pkg::op_set) && set_phase;
	assign ins_addr = pc + cpu_pkg::word_t'(set_fetch);

	assign rd_from = ins_buf.from_reg;
	assign rd_if = ins_buf.if_reg;
	assign alu_op = ins_buf.op;  // Moves get the from register back through the ALU
	assign mem_is_write = (ins_buf.op == cpu_pkg::op_memw);

	assign halted = (state == cpu_pkg::execute) &&
		((ins_buf.op == cpu_pkg::op_halt) || (ins_buf.op == cpu_pkg::op_bus));

	always_comb begin
		if (state == cpu_pkg::commit) begin
			pc_step = (ins_buf.op == cpu_pkg::op_set) ? 2'd2 : 2'd1;
		end else begin
			pc_step = 2'd0;
		end
	end

	// Conditional moves look at the if register
	always_comb begin
		case (ins_buf.op)
			cpu_pkg::op_movnz: move_en = |rdata_if;
			cpu_pkg::op_movez: move_en = ~|rdata_if;
			default:           move_en = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			state <= cpu_pkg::ins_load;
			set_phase <= 1'b0;
			mem_start <= 1'b0;
			reg_wr.en <= 1'b0;
		end else begin
			// Memory ops start in their first execute cycle
			mem_start <= (state == cpu_pkg::ins_load) && ins_is_mem;

			case (state)
				cpu_pkg::ins_load: begin
					ins_buf <= ins_word;
					state <= cpu_pkg::execute;
				end

				cpu_pkg::execute: begin
					case (ins_buf.op)
						cpu_pkg::op_halt, cpu_pkg::op_bus: begin
							state <= cpu_pkg::execute; // Parked here for good
						end
						cpu_pkg::op_set: begin
							if (set_phase) begin
								set_phase <= 1'b0;
								// Pending write doubles as the immediate buffer
								reg_wr <= '{en: 1'b1, addr: ins_buf.to_reg, data: ins_data};
								state <= cpu_pkg::commit;
							end else begin
								set_phase <= 1'b1;
							end
						end
						cpu_pkg::op_memr: begin
							if (mem_done) begin
								reg_wr <= '{en: 1'b1, addr: ins_buf.to_reg, data: mem_rdata};
								state <= cpu_pkg::commit;
							end
						end
						cpu_pkg::op_memw: begin
							if (mem_done) begin
								state <= cpu_pkg::commit;
							end
						end
						default: begin
							// MOV family and the ALU ops
							reg_wr <= '{en: move_en, addr: ins_buf.to_reg, data: alu_result};
							state <= cpu_pkg::commit;
						end
					endcase
				end

				cpu_pkg::commit: begin
					reg_wr.en <= 1'b0; // Write lands at this edge
					state <= cpu_pkg::pc_step;
				end

				cpu_pkg::pc_step: state <= cpu_pkg::ins_load;

				default: state <= cpu_pkg::ins_load;
			endcase
		end
	end

	state_legal: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		state inside {cpu_pkg::ins_load, cpu_pkg::execute, cpu_pkg::commit, cpu_pkg::pc_step});

	// Register file sees a write only while committing
	write_in_commit: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		reg_wr.en |-> state == cpu_pkg::commit);

endmodule

//--- rtl/cpu_pkg.sv
// Shared types for the 16-bit CPU core, referenced by scoped name from every RTL file
package cpu_pkg;

	typedef logic [15:0] word_t;   // Data, address and instruction word
	typedef logic [3:0] reg_addr_t;

	// Opcode values follow the original instruction set
	typedef enum logic [3:0] {
		op_halt  = 4'h0,
		op_mov   = 4'h1,
		op_movnz = 4'h2,
		op_movez = 4'h3,
		op_bus   = 4'h4, // Unimplemented, treated as halt
		op_memr  = 4'h5,
		op_set   = 4'h6, // Immediate in the next word
		op_memw  = 4'h7,
		op_and   = 4'h8,
		op_or    = 4'h9,
		op_xor   = 4'ha,
		op_add   = 4'hb,
		op_shft  = 4'hc,
		op_mul   = 4'hd,
		op_gt    = 4'he,
		op_eq    = 4'hf
	} opcode_e;

	typedef struct packed {
		reg_addr_t if_reg;   // Condition or second operand
		reg_addr_t to_reg;   // Destination
		reg_addr_t from_reg; // Source or address
		opcode_e op;
	} instruction_t;

	typedef enum logic [2:0] {
		ins_load = 3'd0,
		execute  = 3'd1,
		commit   = 3'd2,
		pc_step  = 3'd3
	} cpu_state_e;

	// Data memory request, one access at a time
	typedef struct packed {
		logic read;  // Level, held until ready
		logic write; // Single cycle strobe
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic en;
		reg_addr_t addr;
		word_t data;
	} reg_write_t;

endpackage

//--- rtl/cpu_top.sv
// CPU top level, connects sequencer, register file, ALU and memory access to the ports
`timescale 1ns/10ps

module cpu_top #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic clk,
	input  logic mem_read_ready_stor_reset,
	output cpu_pkg::word_t ins_addr,
	input  cpu_pkg::word_t ins_data,
	output cpu_pkg::mem_req_t mem_req,
	input  cpu_pkg::word_t mem_rdata,
	input  logic mem_read_ready,
	output logic halted
);

	cpu_pkg::word_t pc;
	cpu_pkg::reg_addr_t rd_from, rd_if;
	cpu_pkg::word_t rdata_from, rdata_if;
	cpu_pkg::opcode_e alu_op;
	cpu_pkg::word_t alu_result;
	cpu_pkg::reg_write_t reg_wr;
	logic [1:0] pc_step;

	logic mem_start, mem_is_write, mem_done;
	cpu_pkg::word_t mem_data; // Read data held by the memory sequencer

	cpu_control cpu_control_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.ins_addr                  (ins_addr),
		.ins_data                  (ins_data),
		.pc                        (pc),
		.rd_from                   (rd_from),
		.rd_if                     (rd_if),
		.rdata_if                  (rdata_if),
		.alu_op                    (alu_op),
		.alu_result                (alu_result),
		.mem_start                 (mem_start),
		.mem_is_write              (mem_is_write),
		.mem_done                  (mem_done),
		.mem_rdata                 (mem_data),
		.reg_wr                    (reg_wr),
		.pc_step                   (pc_step),
		.halted                    (halted)
	);

	register_file #(.reset_pc(reset_pc)) register_file_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.rd_from                   (rd_from),
		.rd_if                     (rd_if),
		.rdata_from                (rdata_from),
		.rdata_if                  (rdata_if),
		.reg_wr                    (reg_wr),
		.pc_step                   (pc_step),
		.pc                        (pc)
	);

	alu alu_i (
		.op     (alu_op),
		.a      (rdata_from),
		.b      (rdata_if),
		.result (alu_result)
	);

	// From register is the address, if register the store data
	mem_access mem_access_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.start                     (mem_start),
		.is_write                  (mem_is_write),
		.addr                      (rdata_from),
		.wdata                     (rdata_if),
		.mem_req                   (mem_req),
		.mem_rdata                 (mem_rdata),
		.mem_read_ready            (mem_read_ready),
		.done                      (mem_done),
		.rdata                     (mem_data)
	);

endmodule

//--- rtl/mem_access.sv
// Data memory sequencer for MEMR and MEMW, drives the strobes and holds read data
`timescale 1ns/10ps

module mem_access (
	input  logic clk,
	input  logic mem_read_ready_stor_reset,
	input  logic start,
	input  logic is_write,
	input  cpu_pkg::word_t addr,
	input  cpu_pkg::word_t wdata,
	output cpu_pkg::mem_req_t mem_req,
	input  cpu_pkg::word_t mem_rdata,
	input  logic mem_read_ready,
	output logic done,
	output cpu_pkg::word_t rdata
);

	logic rd_pend;     // Read level after the start cycle
	logic ready_stor;  // Ready pulse seen, held until done
	logic wr_done;
	logic read_hit;

	assign mem_req = '{
		read:  (start & ~is_write) | rd_pend,
		write: start & is_write,
		addr:  addr,
		wdata: wdata
	};

	assign read_hit = mem_req.read && mem_read_ready;
	assign done = ready_stor | wr_done;

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			rd_pend <= 1'b0;
			ready_stor <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			wr_done <= start & is_write; // Write completes the cycle after its strobe

			if (read_hit) begin
				rd_pend <= 1'b0;
			end else if (start && !is_write) begin
				rd_pend <= 1'b1;
			end

			// Capture the pulse, drop it once done has been shown
			if (read_hit) begin
				ready_stor <= 1'b1;
			end else if (ready_stor) begin
				ready_stor <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (read_hit) begin
			rdata <= mem_rdata;
		end
	end

	no_read_and_write: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		!(mem_req.read && mem_req.write));

	// Memory samples the address any time while the read is pending
	read_addr_stable: assert property (@(posedge clk) disable iff (mem_read_ready_stor_reset)
		$past(mem_req.read) && mem_req.read |-> $stable(mem_req.addr));

endmodule

//--- rtl/register_file.sv
// Sixteen general registers plus program counter, two asynchronous read ports, one write port
`timescale 1ns/10ps

module register_file #(
	parameter cpu_pkg::word_t reset_pc = '0
) (
	input  logic clk,
	input  logic mem_read_ready_stor_reset,
	input  cpu_pkg::reg_addr_t rd_from,
	input  cpu_pkg::reg_addr_t rd_if,
	output cpu_pkg::word_t rdata_from,
	output cpu_pkg::word_t rdata_if,
	input  cpu_pkg::reg_write_t reg_wr,
	input  logic [1:0] pc_step,
	output cpu_pkg::word_t pc
);

	cpu_pkg::word_t regs [16];

	assign rdata_from = regs[rd_from];
	assign rdata_if = regs[rd_if];

	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_wr.en) begin
			regs[reg_wr.addr] <= reg_wr.data;
		end
	end

	// Step is 0 except during commit, 2 skips the SET immediate
	always_ff @(posedge clk) begin
		if (mem_read_ready_stor_reset) begin
			pc <= reset_pc;
		end else begin
			pc <= pc + cpu_pkg::word_t'(pc_step);
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator, runs it and checks the log for the pass message

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module cpu_tb -f build.f \
	--Mdir obj_dir -o cpu_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cpu_tb_sim > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
	exit 0
else
	echo "Pass message not found in $log_file"
	exit 1
fi

//--- verification/cpu_tb.sv
// Top testbench for the CPU, runs a random program and checks writes and final state against a model
`timescale 1ns/10ps

module cpu_tb;

	localparam int prog_len = 200;
	localparam int reset_cycles = 16;
	localparam int cycle_limit = prog_len * (5 + 4 + 1) + reset_cycles + 100;

	logic clk;
	logic mem_read_ready_stor_reset;
	cpu_pkg::word_t ins_addr;
	cpu_pkg::word_t ins_data;
	cpu_pkg::mem_req_t mem_req;
	cpu_pkg::word_t mem_rdata;
	logic mem_read_ready;
	logic halted;
	int write_total;

	cpu_pkg::word_t program_words [256];
	cpu_pkg::word_t model_mem [65536];
	cpu_pkg::word_t model_regs [16];
	cpu_pkg::word_t exp_addr [$];
	cpu_pkg::word_t exp_data [$];
	cpu_pkg::word_t final_pc;
	integer seed;
	int exp_index = 0;
	int monitor_errors = 0;
	int final_errors = 0;
	int cycle_count = 0;
	logic halt_seen = 1'b0;

	tb_clock #(.half_period(50), .reset_cycles(reset_cycles)) tb_clock_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset)
	);

	cpu_tb_memory #(.seed_init(32'hedf)) cpu_tb_memory_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.program_words             (program_words),
		.ins_addr                  (ins_addr),
		.ins_data                  (ins_data),
		.mem_req                   (mem_req),
		.mem_rdata                 (mem_rdata),
		.mem_read_ready            (mem_read_ready),
		.write_total               (write_total)
	);

	cpu_top #(.reset_pc(16'h0000)) cpu_top_i (
		.clk                       (clk),
		.mem_read_ready_stor_reset (mem_read_ready_stor_reset),
		.ins_addr                  (ins_addr),
		.ins_data                  (ins_data),
		.mem_req                   (mem_req),
		.mem_rdata                 (mem_rdata),
		.mem_read_ready            (mem_read_ready),
		.halted                    (halted)
	);

	function automatic cpu_pkg::word_t initial_word(input cpu_pkg::word_t a);
		return {a[7:0], a[15:8]} ^ 16'ha55a; // Same background as the memory model
	endfunction

	// Mix of small addresses, shift amounts, zeros and full words
	function automatic cpu_pkg::word_t random_operand();
		logic [1:0] kind;
		cpu_pkg::word_t raw;
		kind = 2'($random(seed));
		raw = 16'($random(seed));
		case (kind)
			2'd0: return {11'h000, raw[4:0]};
			2'd1: return {7'h00, raw[8], 4'h0, raw[3:0]};
			2'd2: return 16'h0000;
			default: return raw;
		endcase
	endfunction

	function automatic cpu_pkg::opcode_e pick_opcode();
		logic [3:0] r;
		r = 4'($random(seed));
		case (r)
			4'd0: return cpu_pkg::op_mov;
			4'd1: return cpu_pkg::op_movnz;
			4'd2: return cpu_pkg::op_movez;
			4'd3, 4'd4: return cpu_pkg::op_memr;
			4'd5, 4'd6: return cpu_pkg::op_memw;
			4'd7: return cpu_pkg::op_set;
			default: return cpu_pkg::opcode_e'(r); // 8 to F are the ALU codes
		endcase
	endfunction

	function automatic cpu_pkg::word_t expected_alu(input cpu_pkg::opcode_e op,
			input cpu_pkg::word_t a, input cpu_pkg::word_t b);
		cpu_pkg::word_t r;
		case (op)
			cpu_pkg::op_and: r = a & b;
			cpu_pkg::op_or:  r = a | b;
			cpu_pkg::op_xor: r = a ^ b;
			cpu_pkg::op_add: r = a + b;
			cpu_pkg::op_mul: r = a * b; // Truncated to 16 bits
			cpu_pkg::op_gt:  r = (a > b) ? 16'hffff : 16'h0000;
			cpu_pkg::op_eq:  r = (a == b) ? 16'hffff : 16'h0000;
			default: begin
				if (b[7:0] >= 8'd16) begin
					r = 16'h0000;
				end else if (b[15:8] != 8'h00) begin
					r = a << b[7:0];
				end else begin
					r = a >> b[7:0];
				end
			end
		endcase
		return r;
	endfunction

	task automatic build_program();
		cpu_pkg::instruction_t ins;
		int pos;
		for (int i = 0; i < 256; i++) begin
			program_words[i] = 16'h0000;
		end
		pos = 0;
		for (int r = 0; r < 16; r++) begin
			ins = '{if_reg: 4'h0, to_reg: 4'(r), from_reg: 4'h0, op: cpu_pkg::op_set};
			program_words[pos] = ins;
			program_words[pos + 1] = random_operand();
			pos += 2;
		end
		// Last word stays HALT
		while (pos < prog_len - 1) begin
			ins.op = pick_opcode();
			ins.if_reg = 4'($random(seed));
			ins.to_reg = 4'($random(seed));
			ins.from_reg = 4'($random(seed));
			if (ins.op == cpu_pkg::op_set && pos + 2 > prog_len - 1) begin
				ins.op = cpu_pkg::op_mov; // No room for the immediate
			end
			program_words[pos] = ins;
			if (ins.op == cpu_pkg::op_set) begin
				program_words[pos + 1] = random_operand();
				pos += 2;
			end else begin
				pos += 1;
			end
		end
	endtask

	task automatic predict_run();
		cpu_pkg::instruction_t ins;
		cpu_pkg::word_t pc;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		logic done;
		pc = 16'h0000;
		done = 1'b0;
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = 16'h0000;
		end
		for (int step = 0; step < prog_len && !done; step++) begin
			ins = cpu_pkg::instruction_t'(program_words[pc[7:0]]);
			a = model_regs[ins.from_reg];
			b = model_regs[ins.if_reg];
			case (ins.op)
				cpu_pkg::op_halt, cpu_pkg::op_bus: done = 1'b1;
				cpu_pkg::op_mov: model_regs[ins.to_reg] = a;
				cpu_pkg::op_movnz: if (b != 16'h0000) model_regs[ins.to_reg] = a;
				cpu_pkg::op_movez: if (b == 16'h0000) model_regs[ins.to_reg] = a;
				cpu_pkg::op_set: model_regs[ins.to_reg] = program_words[8'(pc + 16'd1)];
				cpu_pkg::op_memr: model_regs[ins.to_reg] = model_mem[a];
				cpu_pkg::op_memw: begin
					model_mem[a] = b;
					exp_addr.push_back(a);
					exp_data.push_back(b);
				end
				default: model_regs[ins.to_reg] = expected_alu(ins.op, a, b);
			endcase
			if (!done) begin
				pc = pc + ((ins.op == cpu_pkg::op_set) ? 16'd2 : 16'd1);
			end
		end
		final_pc = pc;
	endtask

	always @(posedge clk) begin
		cycle_count++;
	end

	// Write sequence, reset and halt behavior, looked at mid-cycle
	always @(negedge clk) begin
		if (mem_read_ready_stor_reset) begin
			if (mem_req.read || mem_req.write || halted) begin
				$display("Memory strobe or halted active during reset");
				monitor_errors++;
			end
		end else begin
			if (mem_req.write) begin
				if (exp_index >= exp_addr.size()) begin
					$display("Extra data memory write beyond the expected sequence");
					monitor_errors++;
				end else begin
					if (mem_req.addr != exp_addr[exp_index]) begin
						$display("Fail mem_req.addr: got %h, expected %h",
							mem_req.addr, exp_addr[exp_index]);
						monitor_errors++;
					end
					if (mem_req.wdata != exp_data[exp_index]) begin
						$display("Fail mem_req.wdata: got %h, expected %h",
							mem_req.wdata, exp_data[exp_index]);
						monitor_errors++;
					end
				end
				exp_index++;
			end
			if (halt_seen && !halted) begin
				$display("Halted dropped after the CPU had stopped");
				monitor_errors++;
			end
			if (halt_seen && (mem_req.read || mem_req.write)) begin
				$display("Memory strobe active after halt");
				monitor_errors++;
			end
			if (halted) begin
				halt_seen = 1'b1;
			end
		end
	end

	initial begin
		seed = 32'hedf;
		build_program();
		for (int a = 0; a < 65536; a++) begin
			model_mem[a] = initial_word(16'(a));
		end
		predict_run();

		while (mem_read_ready_stor_reset) @(negedge clk);
		while (!halted && cycle_count < cycle_limit) @(negedge clk);

		if (!halted) begin
			$display("Timeout, CPU did not halt within %0d cycles", cycle_limit);
			final_errors++;
		end else begin
			repeat (8) @(negedge clk); // Halt must hold
			if (ins_addr != final_pc) begin
				$display("Fail ins_addr: got %h, expected %h", ins_addr, final_pc);
				final_errors++;
			end
			if (write_total != exp_addr.size()) begin
				$display("Write count wrong, %0d writes seen but %0d expected",
					write_total, exp_addr.size());
				final_errors++;
			end
			for (int a = 0; a < 65536; a++) begin
				if (cpu_tb_memory_i.data_mem[a] != model_mem[a]) begin
					$display("Fail data_mem[%h]: got %h, expected %h",
						16'(a), cpu_tb_memory_i.data_mem[a], model_mem[a]);
					final_errors++;
				end
			end
		end

		$display("Summary: %0d writes, %0d run errors, %0d end errors",
			write_total, monitor_errors, final_errors);
		if (monitor_errors + final_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verification/cpu_tb_memory.sv
// Behavioral program and data memory for the CPU testbench, reads answer after a random latency
`timescale 1ns/10ps

module cpu_tb_memory #(
	parameter integer seed_init = 32'hedf
) (
	input  logic clk,
	input  logic mem_read_ready_stor_reset,
	input  cpu_pkg::word_t program_words [256],
	input  cpu_pkg::word_t ins_addr,
	output cpu_pkg::word_t ins_data,
	input  cpu_pkg::mem_req_t mem_req,
	output cpu_pkg::word_t mem_rdata,
	output logic mem_read_ready,
	output int write_total
);

	cpu_pkg::word_t data_mem [65536];
	integer seed;
	int wait_left;
	logic read_busy;

	// Background contents, every address bit matters
	function automatic cpu_pkg::word_t fill_value(input cpu_pkg::word_t a);
		return {a[7:0], a[15:8]} ^ 16'ha55a;
	endfunction

	// Past the program everything reads as HALT
	assign ins_data = (ins_addr < 16'd256) ? program_words[ins_addr[7:0]] : 16'h0000;

	initial begin
		seed = seed_init;
		mem_rdata = '0;
		mem_read_ready = 1'b0;
		read_busy = 1'b0;
		wait_left = 0;
		write_total = 0;
		for (int a = 0; a < 65536; a++) begin
			data_mem[a] = fill_value(16'(a));
		end
	end

	always @(negedge clk) begin
		if (mem_read_ready_stor_reset) begin
			mem_read_ready = 1'b0;
			read_busy = 1'b0;
		end else begin
			if (mem_req.write) begin
				data_mem[mem_req.addr] = mem_req.wdata;
				write_total++;
			end
			if (mem_read_ready) begin
				mem_read_ready = 1'b0; // Single cycle pulse
			end else if (mem_req.read) begin
				if (!read_busy) begin
					read_busy = 1'b1;
					wait_left = 1 + int'($unsigned($random(seed)) % 32'd4);
				end
				wait_left--;
				if (wait_left == 0) begin
					mem_rdata = data_mem[mem_req.addr];
					mem_read_ready = 1'b1;
					read_busy = 1'b0;
				end
			end
		end
	end

endmodule

//--- verification/tb_clock.sv
// Testbench clock and reset source, free running clock with reset held for a set number of cycles
`timescale 1ns/10ps

module tb_clock #(
	parameter int half_period = 50,
	parameter int reset_cycles = 16
) (
	output logic clk,
	output logic mem_read_ready_stor_reset
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	initial begin
		mem_read_ready_stor_reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		mem_read_ready_stor_reset = 1'b0; // Released on a falling edge
	end

endmodule
